/* filelist.f */
+incdir+.
disc_pkg.sv
disc_frontend.sv
sample_delay_line.sv
channel_discriminator.sv
burst_timestamper.sv
sample_discriminator.sv
disc_monitor.sv
disc_chk.sv
tb_sample_discriminator.sv

/* run_sim.sh */
#!/bin/sh
# build and run the discriminator testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sample_discriminator -o sim_tb \
    -f filelist.f > build.log 2>&1; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" sim.log; then
  exit 0
fi
echo "simulation reported failures"
exit 1

/* tb_sample_discriminator.sv */
// sample discriminator testbench

`timescale 1ns/1ps
`include "disc_config.svh"

module tb_sample_discriminator;

  localparam int CH     = `DISC_CHANNELS;
  localparam int ADDR_W = $clog2(`DISC_CHANNELS) + 2;
  localparam int ROWS   = 6;

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  // delays word has start in 3..0, stop in 7..4 and digital delay in 11..8
  localparam logic [15:0] ROW_DELAYS [ROWS][CH] = '{
    '{16'h0000, 16'h0000},
    '{16'h0053, 16'h0027},
    '{16'h00ff, 16'h0090},
    '{16'h0432, 16'h0f05},
    '{16'h0000, 16'h0011},
    '{16'h0500, 16'h0004}
  };
  // source word has the source in 1..0 and the disable flag in bit 4
  localparam logic [15:0] ROW_SOURCE [ROWS][CH] = '{
    '{16'h0000, 16'h0001},
    '{16'h0001, 16'h0000},
    '{16'h0000, 16'h0001},
    '{16'h0002, 16'h0003},
    '{16'h0010, 16'h0001},
    '{16'h0003, 16'h0012}
  };
  localparam int ROW_SPACING [ROWS] = '{1, 1, 2, 2, 1, 1};
  localparam int ROW_RANGE   [ROWS] = '{1000, 3000, 500, 800, 1000, 2000};
  // -1 means no trigger pulse in that row
  localparam int ROW_TRIG_AT [ROWS] = '{-1, -1, -1, 40, 10, 25};
  localparam int ROW_COUNT   [ROWS] = '{120, 150, 120, 100, 60, 80};

  logic                   adc_clk;
  logic                   rst_n;
  logic                   adc_valid;
  logic [CH-1:0][15:0]    adc_data;
  logic [`DISC_TRIG_CHANNELS-1:0] adc_trigger;
  logic                   reset_state;
  logic                   cfg_we;
  logic [ADDR_W-1:0]      cfg_addr;
  logic [15:0]            cfg_data;
  logic [CH-1:0]          data_valid;
  logic [CH-1:0][15:0]    data;
  logic [CH-1:0]          ts_valid;
  logic [CH-1:0][31:0]    ts;

  sample_discriminator dut (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n),
    .adc_valid_i   (adc_valid),
    .adc_data_i    (adc_data),
    .adc_trigger_i (adc_trigger),
    .reset_state_i (reset_state),
    .cfg_we_i      (cfg_we),
    .cfg_addr_i    (cfg_addr),
    .cfg_data_i    (cfg_data),
    .data_valid_o  (data_valid),
    .data_o        (data),
    .ts_valid_o    (ts_valid),
    .ts_o          (ts)
  );

  disc_monitor u_mon (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n),
    .adc_valid_i   (adc_valid),
    .adc_data_i    (adc_data),
    .adc_trigger_i (adc_trigger),
    .reset_state_i (reset_state),
    .cfg_we_i      (cfg_we),
    .cfg_addr_i    (cfg_addr),
    .cfg_data_i    (cfg_data),
    .data_valid_i  (data_valid),
    .data_i        (data),
    .ts_valid_i    (ts_valid),
    .ts_i          (ts)
  );

  bind sample_discriminator disc_chk u_chk (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .reset_state_i (reset_state_i),
    .data_valid_i  (data_valid_o),
    .ts_valid_i    (ts_valid_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  task automatic next_cycle();
    @(posedge adc_clk);
    #5;
  endtask

  task automatic write_cfg(input int ch, input disc_pkg::cfg_reg_e idx, input logic [15:0] value);
    cfg_we   = 1'b1;
    cfg_addr = ADDR_W'(ch * 4 + int'(idx));
    cfg_data = value;
    next_cycle();
    cfg_we   = 1'b0;
  endtask

  function automatic logic [15:0] random_sample(input int range);
    return 16'(int'($urandom_range(2 * range, 0)) - range);
  endfunction

  task automatic pulse_state_reset();
    reset_state = 1'b1;
    next_cycle();
    reset_state = 1'b0;
  endtask

  task automatic run_row(input int r);
    logic [15:0] low;
    logic [15:0] high;
    int          half;
    int          trig_at;
    half    = ROW_RANGE[r] / 2;
    trig_at = ROW_TRIG_AT[r];
    // thresholds drawn around zero with high never below low
    for (int c = 0; c < CH; c++) begin
      low  = 16'(int'($urandom_range(ROW_RANGE[r], 0)) - half);
      high = low + 16'($urandom_range(half, 0));
      write_cfg(c, disc_pkg::LOW_THR, low);
      write_cfg(c, disc_pkg::HIGH_THR, high);
      write_cfg(c, disc_pkg::DELAYS, ROW_DELAYS[r][c]);
      write_cfg(c, disc_pkg::SOURCE, ROW_SOURCE[r][c]);
    end
    pulse_state_reset();
    repeat (2) next_cycle();
    for (int n = 0; n < ROW_COUNT[r]; n++) begin
      adc_valid = 1'b1;
      for (int c = 0; c < CH; c++) begin
        adc_data[c] = random_sample(ROW_RANGE[r]);
      end
      // three-sample pulse on every trigger bit
      adc_trigger = (trig_at >= 0 && n >= trig_at && n < trig_at + 3) ? '1 : '0;
      next_cycle();
      adc_valid = 1'b0;
      repeat (ROW_SPACING[r] - 1) next_cycle();
    end
    adc_trigger = '0;
    repeat (8) next_cycle();
  endtask

  function automatic int run_length_cycles();
    int total;
    total = 16 + 200;
    for (int r = 0; r < ROWS; r++) begin
      total += ROW_COUNT[r] * ROW_SPACING[r] + 40;
    end
    return total;
  endfunction

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h16ca7274));
    rst_n       = 1'b0;
    adc_valid   = 1'b0;
    adc_data    = '0;
    adc_trigger = '0;
    reset_state = 1'b0;
    cfg_we      = 1'b0;
    cfg_addr    = '0;
    cfg_data    = '0;
    repeat (16) @(posedge adc_clk);
    #5;
    rst_n = 1'b1;
    next_cycle();
    for (int r = 0; r < ROWS; r++) begin
      run_row(r);
    end
    // state reset with kept samples of the last row's setup still in flight
    for (int n = 0; n < 6; n++) begin
      adc_valid = 1'b1;
      for (int c = 0; c < CH; c++) begin
        adc_data[c] = random_sample(ROW_RANGE[ROWS-1]);
      end
      next_cycle();
    end
    adc_valid = 1'b0;
    pulse_state_reset();
    repeat (4) next_cycle();
    $display("closing: %0d samples checked, %0d compare errors, %0d assertion failures",
             u_mon.checked_count, u_mon.error_count, dut.u_chk.fail_count);
    if (u_mon.error_count == 0 && dut.u_chk.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (run_length_cycles()) @(posedge adc_clk);
    $display("watchdog: the run did not finish within %0d cycles", run_length_cycles());
    $display("Done: errors found");
    $finish;
  end

endmodule

/* disc_chk.sv */
// discriminator output assertions

`timescale 1ns/1ps
`include "disc_config.svh"

module disc_chk (
  input logic                      adc_clk,
  input logic                      rst_n_i,
  input logic                      reset_state_i,
  input logic [`DISC_CHANNELS-1:0] data_valid_i,
  input logic [`DISC_CHANNELS-1:0] ts_valid_i
);

  int fail_count = 0;

  // outputs stay quiet while the reset is held
  a_reset_quiet: assert property (@(posedge adc_clk)
    !rst_n_i |=> (data_valid_i == '0) && (ts_valid_i == '0))
    else begin
      $error("output valid active during reset");
      fail_count++;
    end

  a_ts_with_data: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (ts_valid_i & ~data_valid_i) == '0)
    else begin
      $error("timestamp valid without a data valid on the same channel");
      fail_count++;
    end

  // state reset flushes the output stage
  a_state_reset_flush: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    reset_state_i |=> (data_valid_i == '0) && (ts_valid_i == '0))
    else begin
      $error("output valid in the cycle after a state reset");
      fail_count++;
    end

endmodule

/* disc_monitor.sv */
// discriminator reference monitor

`timescale 1ns/1ps
`include "disc_config.svh"

module disc_monitor (
  input  logic                                              adc_clk,
  input  logic                                              rst_n_i,
  input  logic                                              adc_valid_i,
  input  logic [`DISC_CHANNELS-1:0][`DISC_SAMPLE_WIDTH-1:0] adc_data_i,
  input  logic [`DISC_TRIG_CHANNELS-1:0]                    adc_trigger_i,
  input  logic                                              reset_state_i,
  input  logic                                              cfg_we_i,
  input  logic [$clog2(`DISC_CHANNELS)+1:0]                 cfg_addr_i,
  input  logic [`DISC_SAMPLE_WIDTH-1:0]                     cfg_data_i,
  input  logic [`DISC_CHANNELS-1:0]                         data_valid_i,
  input  logic [`DISC_CHANNELS-1:0][`DISC_SAMPLE_WIDTH-1:0] data_i,
  input  logic [`DISC_CHANNELS-1:0]                         ts_valid_i,
  input  logic [`DISC_CHANNELS-1:0][`DISC_TS_WIDTH-1:0]     ts_i
);

  localparam int CH   = `DISC_CHANNELS;
  localparam int HIST = `DISC_MAX_DELAY;

  int error_count   = 0;
  int checked_count = 0;
  int edge_count    = 0;

  disc_pkg::sample_t              low_thr    [CH];
  disc_pkg::sample_t              high_thr   [CH];
  int                             start_dly  [CH];
  int                             stop_dly   [CH];
  int                             dig_dly    [CH];
  int                             source     [CH];
  logic                           disabled   [CH];
  logic                           hyst       [CH];
  logic                           have_prev  [CH];
  int                             prev_index [CH];
  logic                           armed_hist [CH][HIST];
  logic [15:0]                    samp_hist  [CH][HIST];
  logic [`DISC_TRIG_CHANNELS-1:0] trig_hist  [HIST];
  int                             count;
  // expected entry is {burst start, index, sample}
  logic [48:0]                    exp_q      [CH][$];
  // clock edge at which each expected entry was taken
  int                             push_cycle [CH][$];

  task automatic apply_config();
    int c;
    c = int'(cfg_addr_i >> 2);
    case (cfg_addr_i[1:0])
      2'd0: low_thr[c] = cfg_data_i;
      2'd1: high_thr[c] = cfg_data_i;
      2'd2: begin
        start_dly[c] = int'(cfg_data_i[3:0]);
        stop_dly[c]  = int'(cfg_data_i[7:4]);
        dig_dly[c]   = int'(cfg_data_i[11:8]);
      end
      default: begin
        source[c]   = int'(cfg_data_i[1:0]);
        disabled[c] = cfg_data_i[4];
      end
    endcase
  endtask

  task automatic clear_state();
    for (int c = 0; c < CH; c++) begin
      // samples taken in the last two cycles are still in the DUT pipeline and get flushed
      while (push_cycle[c].size() != 0 && push_cycle[c][$] >= edge_count - 2) begin
        void'(push_cycle[c].pop_back());
        void'(exp_q[c].pop_back());
      end
      if (exp_q[c].size() != 0) begin
        $display("channel %0d: %0d expected samples never appeared", c, exp_q[c].size());
        error_count++;
      end
      exp_q[c].delete();
      push_cycle[c].delete();
      hyst[c]      = 1'b0;
      have_prev[c] = 1'b0;
    end
    count = 0;
  endtask

  ////////////////////////////////
  // expected model
  ////////////////////////////////

  // sample n decides whether sample n - start is kept
  task automatic take_sample();
    disc_pkg::sample_t s;
    int                src;
    int                slot;
    int                i;
    logic              armed;
    logic              keep;
    logic              burst;
    slot = count % HIST;
    trig_hist[slot] = adc_trigger_i;
    for (int c = 0; c < CH; c++) begin
      samp_hist[c][slot] = adc_data_i[c];
    end
    for (int c = 0; c < CH; c++) begin
      src = source[c];
      if (src < CH) begin
        s = adc_data_i[src];
        if (s > high_thr[c]) begin
          hyst[c] = 1'b1;
        end else if (s < low_thr[c]) begin
          hyst[c] = 1'b0;
        end
        armed = hyst[c];
      end else if (count >= dig_dly[c]) begin
        armed = trig_hist[(count - dig_dly[c]) % HIST][src - CH];
      end else begin
        armed = 1'b0;
      end
      armed_hist[c][slot] = armed;
      if (count >= start_dly[c]) begin
        i    = count - start_dly[c];
        keep = disabled[c];
        for (int m = count - stop_dly[c]; m <= count; m++) begin
          if (m >= 0 && armed_hist[c][m % HIST]) begin
            keep = 1'b1;
          end
        end
        if (keep) begin
          burst        = !have_prev[c] || (i != prev_index[c] + 1);
          have_prev[c] = 1'b1;
          prev_index[c] = i;
          exp_q[c].push_back({burst, 32'(i), samp_hist[c][i % HIST]});
          push_cycle[c].push_back(edge_count);
        end
      end
    end
    count++;
  endtask

  ////////////////////////////////
  // output compare
  ////////////////////////////////

  task automatic compare_outputs();
    logic [48:0] e;
    for (int c = 0; c < CH; c++) begin
      if (data_valid_i[c]) begin
        if (exp_q[c].size() == 0) begin
          $display("channel %0d: sample 0x%h came out with nothing expected", c, data_i[c]);
          error_count++;
        end else begin
          e = exp_q[c].pop_front();
          void'(push_cycle[c].pop_front());
          checked_count++;
          if (data_i[c] !== e[15:0]) begin
            $display("[ERROR] data_o[%0d] = 0x%h, expected 0x%h (index 0x%h)",
                     c, data_i[c], e[15:0], e[47:16]);
            error_count++;
          end
          if (ts_valid_i[c] !== e[48]) begin
            $display("[ERROR] ts_valid_o[%0d] = 0x%h, expected 0x%h (index 0x%h)",
                     c, ts_valid_i[c], e[48], e[47:16]);
            error_count++;
          end else if (e[48] && ts_i[c] !== e[47:16]) begin
            $display("[ERROR] ts_o[%0d] = 0x%h, expected 0x%h", c, ts_i[c], e[47:16]);
            error_count++;
          end
        end
      end
    end
  endtask

  always @(posedge adc_clk) begin
    if (!rst_n_i) begin
      for (int c = 0; c < CH; c++) begin
        low_thr[c]   = '0;
        high_thr[c]  = '0;
        start_dly[c] = 0;
        stop_dly[c]  = 0;
        dig_dly[c]   = 0;
        source[c]    = 0;
        disabled[c]  = 1'b0;
      end
      clear_state();
    end else begin
      compare_outputs();
      if (cfg_we_i) begin
        apply_config();
      end
      if (reset_state_i) begin
        clear_state();
      end else if (adc_valid_i) begin
        take_sample();
      end
    end
    edge_count++;
  end

endmodule

/* sample_discriminator.sv */
// multichannel sample discriminator

`timescale 1ns/1ps
`include "disc_config.svh"

module sample_discriminator (
  input  logic                                              adc_clk,
  input  logic                                              rst_n_i,
  input  logic                                              adc_valid_i,
  input  logic [`DISC_CHANNELS-1:0][`DISC_SAMPLE_WIDTH-1:0] adc_data_i,
  input  logic [`DISC_TRIG_CHANNELS-1:0]                    adc_trigger_i,
  input  logic                                              reset_state_i,
  input  logic                                              cfg_we_i,
  input  logic [$clog2(`DISC_CHANNELS)+1:0]                 cfg_addr_i,
  input  logic [`DISC_SAMPLE_WIDTH-1:0]                     cfg_data_i,
  output logic [`DISC_CHANNELS-1:0]                         data_valid_o,
  output logic [`DISC_CHANNELS-1:0][`DISC_SAMPLE_WIDTH-1:0] data_o,
  output logic [`DISC_CHANNELS-1:0]                         ts_valid_o,
  output logic [`DISC_CHANNELS-1:0][`DISC_TS_WIDTH-1:0]     ts_o
);

  logic                                          fe_valid;
  disc_pkg::sample_t [`DISC_CHANNELS-1:0]        fe_data;
  logic [`DISC_TRIG_CHANNELS-1:0]                fe_trigger;
  logic [`DISC_TS_WIDTH-1:0]                     fe_index;
  logic                                          fe_clear;
  disc_pkg::sample_t [`DISC_CHANNELS-1:0]        low_thr;
  disc_pkg::sample_t [`DISC_CHANNELS-1:0]        high_thr;
  disc_pkg::delay_t [`DISC_CHANNELS-1:0]         start_delay;
  disc_pkg::delay_t [`DISC_CHANNELS-1:0]         stop_delay;
  disc_pkg::delay_t [`DISC_CHANNELS-1:0]         dig_delay;
  disc_pkg::source_t [`DISC_CHANNELS-1:0]        source;
  logic [`DISC_CHANNELS-1:0]                     chan_disable;
  logic [`DISC_CHANNELS-1:0]                     kept_valid;
  disc_pkg::tagged_sample_t [`DISC_CHANNELS-1:0] kept;

  disc_frontend u_frontend (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .adc_valid_i   (adc_valid_i),
    .adc_data_i    (adc_data_i),
    .adc_trigger_i (adc_trigger_i),
    .reset_state_i (reset_state_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_data_i    (cfg_data_i),
    .valid_o       (fe_valid),
    .data_o        (fe_data),
    .trigger_o     (fe_trigger),
    .index_o       (fe_index),
    .clear_o       (fe_clear),
    .low_thr_o     (low_thr),
    .high_thr_o    (high_thr),
    .start_delay_o (start_delay),
    .stop_delay_o  (stop_delay),
    .dig_delay_o   (dig_delay),
    .source_o      (source),
    .disable_o     (chan_disable)
  );

  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_channel
    channel_discriminator #(
      .CHANNEL(ch)
    ) u_channel (
      .adc_clk       (adc_clk),
      .rst_n_i       (rst_n_i),
      .valid_i       (fe_valid),
      .data_i        (fe_data),
      .trigger_i     (fe_trigger),
      .index_i       (fe_index),
      .clear_i       (fe_clear),
      .low_thr_i     (low_thr[ch]),
      .high_thr_i    (high_thr[ch]),
      .start_delay_i (start_delay[ch]),
      .stop_delay_i  (stop_delay[ch]),
      .dig_delay_i   (dig_delay[ch]),
      .source_i      (source[ch]),
      .disable_i     (chan_disable[ch]),
      .kept_valid_o  (kept_valid[ch]),
      .kept_o        (kept[ch])
    );
  end

  // raw state reset here, the timestamper covers its own pipeline stage
  burst_timestamper u_timestamper (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .clear_i      (reset_state_i),
    .kept_valid_i (kept_valid),
    .kept_i       (kept),
    .data_valid_o (data_valid_o),
    .data_o       (data_o),
    .ts_valid_o   (ts_valid_o),
    .ts_o         (ts_o)
  );

endmodule

/* burst_timestamper.sv */
// burst start timestamper

`timescale 1ns/1ps
`include "disc_config.svh"

module burst_timestamper (
  input  logic                                          adc_clk,
  input  logic                                          rst_n_i,
  input  logic                                          clear_i,
  input  logic [`DISC_CHANNELS-1:0]                     kept_valid_i,
  input  disc_pkg::tagged_sample_t [`DISC_CHANNELS-1:0] kept_i,
  output logic [`DISC_CHANNELS-1:0]                     data_valid_o,
  output disc_pkg::sample_t [`DISC_CHANNELS-1:0]        data_o,
  output logic [`DISC_CHANNELS-1:0]                     ts_valid_o,
  output logic [`DISC_CHANNELS-1:0][`DISC_TS_WIDTH-1:0] ts_o
);

  logic                                          clear_q;
  logic                                          flush;
  logic [`DISC_CHANNELS-1:0]                     have_prev;
  logic [`DISC_CHANNELS-1:0][`DISC_TS_WIDTH-1:0] prev_index;
  logic [`DISC_CHANNELS-1:0]                     take;
  logic [`DISC_CHANNELS-1:0]                     burst_start;

  // clear is the raw state reset, so also drop the stage still in flight
  assign flush = clear_i || clear_q;

  // a burst starts at any break in the run of kept indices
  always_comb begin
    for (int c = 0; c < `DISC_CHANNELS; c++) begin
      take[c]        = kept_valid_i[c] && !flush;
      burst_start[c] = take[c] &&
                       (!have_prev[c] || (kept_i[c].index != prev_index[c] + 1'b1));
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      clear_q      <= 1'b0;
      have_prev    <= '0;
      data_valid_o <= '0;
      ts_valid_o   <= '0;
    end else begin
      clear_q      <= clear_i;
      data_valid_o <= take;
      ts_valid_o   <= burst_start;
      have_prev    <= flush ? '0 : (have_prev | take);
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < `DISC_CHANNELS; c++) begin
      if (take[c]) begin
        data_o[c]     <= kept_i[c].sample;
        prev_index[c] <= kept_i[c].index;
      end
      if (burst_start[c]) begin
        ts_o[c] <= kept_i[c].index;
      end
    end
  end

endmodule

/* channel_discriminator.sv */
// per-channel sample discriminator

`timescale 1ns/1ps
`include "disc_config.svh"

module channel_discriminator #(
  parameter int CHANNEL = 0
) (
  input  logic                                   adc_clk,
  input  logic                                   rst_n_i,
  input  logic                                   valid_i,
  input  disc_pkg::sample_t [`DISC_CHANNELS-1:0] data_i,
  input  logic [`DISC_TRIG_CHANNELS-1:0]         trigger_i,
  input  logic [`DISC_TS_WIDTH-1:0]              index_i,
  input  logic                                   clear_i,
  input  disc_pkg::sample_t                      low_thr_i,
  input  disc_pkg::sample_t                      high_thr_i,
  input  disc_pkg::delay_t                       start_delay_i,
  input  disc_pkg::delay_t                       stop_delay_i,
  input  disc_pkg::delay_t                       dig_delay_i,
  input  disc_pkg::source_t                      source_i,
  input  logic                                   disable_i,
  output logic                                   kept_valid_o,
  output disc_pkg::tagged_sample_t               kept_o
);

  disc_pkg::sample_t        src_sample;
  disc_pkg::tagged_sample_t tagged_in;
  disc_pkg::tagged_sample_t tagged_dly;
  disc_pkg::delay_t         hold_q;
  logic                     trig_bit;
  logic                     trig_dly;
  logic                     digital_src;
  logic                     hyst_q;
  logic                     hyst_next;
  logic                     armed;
  logic                     gate;

  //////////////////////////////
  // trigger source select
  //////////////////////////////

  always_comb begin
    src_sample = data_i[0];
    trig_bit   = 1'b0;
    for (int c = 0; c < `DISC_CHANNELS; c++) begin
      if (source_i == disc_pkg::source_t'(c)) begin
        src_sample = data_i[c];
      end
    end
    for (int t = 0; t < `DISC_TRIG_CHANNELS; t++) begin
      if (source_i == disc_pkg::source_t'(`DISC_CHANNELS + t)) begin
        trig_bit = trigger_i[t];
      end
    end
  end

  assign digital_src = (source_i >= disc_pkg::source_t'(`DISC_CHANNELS));

  sample_delay_line #(
    .payload_t(logic)
  ) u_trig_dly (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .clear_i   (clear_i),
    .shift_i   (valid_i),
    .delay_i   (dig_delay_i),
    .payload_i (trig_bit),
    .payload_o (trig_dly)
  );

  // hysteresis, holds its state between the two thresholds
  always_comb begin
    hyst_next = hyst_q;
    if (src_sample > high_thr_i) begin
      hyst_next = 1'b1;
    end else if (src_sample < low_thr_i) begin
      hyst_next = 1'b0;
    end
  end

  assign armed = digital_src ? trig_dly : hyst_next;

  // gate stays open for stop_delay samples after armed falls
  assign gate = armed || (hold_q != '0);

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i || clear_i) begin
      hyst_q <= 1'b0;
      hold_q <= '0;
    end else if (valid_i) begin
      hyst_q <= hyst_next;
      if (armed) begin
        hold_q <= stop_delay_i;
      end else if (hold_q != '0) begin
        hold_q <= hold_q - 1'b1;
      end
    end
  end

  //////////////////////////////
  // pre-trigger data delay
  //////////////////////////////

  always_comb begin
    tagged_in.valid  = 1'b1;
    tagged_in.index  = index_i;
    tagged_in.sample = data_i[CHANNEL];
  end

  sample_delay_line #(
    .payload_t(disc_pkg::tagged_sample_t)
  ) u_data_dly (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .clear_i   (clear_i),
    .shift_i   (valid_i),
    .delay_i   (start_delay_i),
    .payload_i (tagged_in),
    .payload_o (tagged_dly)
  );

  // empty slots left by a clear carry no valid tag and are dropped
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      kept_valid_o <= 1'b0;
    end else begin
      kept_valid_o <= valid_i && !clear_i && tagged_dly.valid && (gate || disable_i);
    end
  end

  always_ff @(posedge adc_clk) begin
    kept_o <= tagged_dly;
  end

endmodule

/* sample_delay_line.sv */
// valid-sample delay line

`timescale 1ns/1ps
`include "disc_config.svh"

module sample_delay_line #(
  parameter type payload_t = logic
) (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic             clear_i,
  input  logic             shift_i,
  input  disc_pkg::delay_t delay_i,
  input  payload_t         payload_i,
  output payload_t         payload_o
);

  // the live input acts as tap 0, so only depth - 1 stages are stored
  localparam int STAGES = `DISC_MAX_DELAY - 1;

  payload_t stages [STAGES];

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i || clear_i) begin
      for (int i = 0; i < STAGES; i++) begin
        stages[i] <= '0;
      end
    end else if (shift_i) begin
      stages[0] <= payload_i;
      for (int i = 1; i < STAGES; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  // tap n holds the payload from n shifts ago
  assign payload_o = (delay_i == '0) ? payload_i : stages[delay_i - 1'b1];

endmodule

/* disc_frontend.sv */
// ADC input front end

`timescale 1ns/1ps
`include "disc_config.svh"

module disc_frontend (
  input  logic                                              adc_clk,
  input  logic                                              rst_n_i,
  input  logic                                              adc_valid_i,
  input  logic [`DISC_CHANNELS-1:0][`DISC_SAMPLE_WIDTH-1:0] adc_data_i,
  input  logic [`DISC_TRIG_CHANNELS-1:0]                    adc_trigger_i,
  input  logic                                              reset_state_i,
  input  logic                                              cfg_we_i,
  input  logic [$clog2(`DISC_CHANNELS)+1:0]                 cfg_addr_i,
  input  logic [`DISC_SAMPLE_WIDTH-1:0]                     cfg_data_i,
  output logic                                              valid_o,
  output disc_pkg::sample_t [`DISC_CHANNELS-1:0]            data_o,
  output logic [`DISC_TRIG_CHANNELS-1:0]                    trigger_o,
  output logic [`DISC_TS_WIDTH-1:0]                         index_o,
  output logic                                              clear_o,
  output disc_pkg::sample_t [`DISC_CHANNELS-1:0]            low_thr_o,
  output disc_pkg::sample_t [`DISC_CHANNELS-1:0]            high_thr_o,
  output disc_pkg::delay_t [`DISC_CHANNELS-1:0]             start_delay_o,
  output disc_pkg::delay_t [`DISC_CHANNELS-1:0]             stop_delay_o,
  output disc_pkg::delay_t [`DISC_CHANNELS-1:0]             dig_delay_o,
  output disc_pkg::source_t [`DISC_CHANNELS-1:0]            source_o,
  output logic [`DISC_CHANNELS-1:0]                         disable_o
);

  localparam int CH_W  = $clog2(`DISC_CHANNELS);
  localparam int DLY_W = $bits(disc_pkg::delay_t);
  localparam int SRC_W = $bits(disc_pkg::source_t);

  logic [`DISC_TS_WIDTH-1:0] sample_count;

  //////////////////////////////
  // input registers
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      valid_o      <= 1'b0;
      clear_o      <= 1'b0;
      sample_count <= '0;
    end else begin
      valid_o <= adc_valid_i;
      clear_o <= reset_state_i;
      // first valid sample after a state reset gets index 0
      if (reset_state_i) begin
        sample_count <= '0;
      end else if (adc_valid_i) begin
        sample_count <= sample_count + 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    data_o    <= adc_data_i;
    trigger_o <= adc_trigger_i;
    index_o   <= sample_count;
  end

  //////////////////////////////
  // configuration registers
  //////////////////////////////

  // address is channel * 4 + register index
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      low_thr_o     <= '0;
      high_thr_o    <= '0;
      start_delay_o <= '0;
      stop_delay_o  <= '0;
      dig_delay_o   <= '0;
      source_o      <= '0;
      disable_o     <= '0;
    end else if (cfg_we_i) begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        if (cfg_addr_i[2 +: CH_W] == CH_W'(ch)) begin
          case (disc_pkg::cfg_reg_e'(cfg_addr_i[1:0]))
            disc_pkg::LOW_THR:  low_thr_o[ch]  <= cfg_data_i;
            disc_pkg::HIGH_THR: high_thr_o[ch] <= cfg_data_i;
            disc_pkg::DELAYS: begin
              start_delay_o[ch] <= cfg_data_i[0 +: DLY_W];
              stop_delay_o[ch]  <= cfg_data_i[4 +: DLY_W];
              dig_delay_o[ch]   <= cfg_data_i[8 +: DLY_W];
            end
            disc_pkg::SOURCE: begin
              source_o[ch]  <= cfg_data_i[0 +: SRC_W];
              disable_o[ch] <= cfg_data_i[4];
            end
          endcase
        end
      end
    end
  end

endmodule

/* disc_pkg.sv */
// discriminator types

`include "disc_config.svh"

package disc_pkg;

  // signed ADC sample
  typedef logic signed [`DISC_SAMPLE_WIDTH-1:0] sample_t;

  // delay in valid samples
  typedef logic [$clog2(`DISC_MAX_DELAY)-1:0] delay_t;

  // trigger source, analog channels first, then digital trigger bits
  typedef logic [$clog2(`DISC_CHANNELS + `DISC_TRIG_CHANNELS)-1:0] source_t;

  // sample with its index since the last state reset
  typedef struct packed {
    logic                      valid;
    logic [`DISC_TS_WIDTH-1:0] index;
    sample_t                   sample;
  } tagged_sample_t;

  // register index within one channel's block of four
  typedef enum logic [1:0] {
    LOW_THR  = 2'd0,
    HIGH_THR = 2'd1,
    DELAYS   = 2'd2,
    SOURCE   = 2'd3
  } cfg_reg_e;

endpackage

/* disc_config.svh */
// discriminator sizes

`ifndef DISC_CONFIG_SVH
`define DISC_CONFIG_SVH

// number of receive channels
`define DISC_CHANNELS 2

// number of transmit-side digital trigger bits
`define DISC_TRIG_CHANNELS 2

// ADC sample width in bits
`define DISC_SAMPLE_WIDTH 16

// depth of each delay line, delays run from 0 to depth - 1
`define DISC_MAX_DELAY 16

// sample counter and timestamp width
`define DISC_TS_WIDTH 32

`endif
